// File: design/axil_sram_pkg.sv
package axil_sram_pkg;

  localparam int AXIL_ADDR_WIDTH = 16;
  localparam int AXIL_DATA_WIDTH = 16;
  localparam int STRB_WIDTH = AXIL_DATA_WIDTH / 8;

  // byte offset bits within one data word
  localparam int WORD_LSB = $clog2(AXIL_DATA_WIDTH) - 3;
  localparam int SRAM_ADDR_WIDTH = AXIL_ADDR_WIDTH - WORD_LSB;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  typedef struct packed {
    logic [SRAM_ADDR_WIDTH-1:0] addr;
    logic                       wr_en;
    logic [AXIL_DATA_WIDTH-1:0] wr_data;
    logic [STRB_WIDTH-1:0]      wr_strb;
  } sram_cmd_t;

  typedef struct packed {
    logic [AXIL_DATA_WIDTH-1:0] rd_data;
  } sram_rd_t;

endpackage

// File: design/axil_sram_bridge.sv
module axil_sram_bridge (
  input  logic                                     clk,
  input  logic                                     rst_n,

  input  logic [axil_sram_pkg::AXIL_ADDR_WIDTH-1:0] awaddr,
  input  logic                                     awvalid,
  output logic                                     awready,
  input  logic [axil_sram_pkg::AXIL_DATA_WIDTH-1:0] wdata,
  input  logic [axil_sram_pkg::STRB_WIDTH-1:0]      wstrb,
  input  logic                                     wvalid,
  output logic                                     wready,
  output logic [1:0]                               bresp,
  output logic                                     bvalid,
  input  logic                                     bready,

  input  logic [axil_sram_pkg::AXIL_ADDR_WIDTH-1:0] araddr,
  input  logic                                     arvalid,
  output logic                                     arready,
  output logic [axil_sram_pkg::AXIL_DATA_WIDTH-1:0] rdata,
  output logic [1:0]                               rresp,
  output logic                                     rvalid,
  input  logic                                     rready,

  output logic                                     cmd_valid,
  input  logic                                     cmd_ready,
  output axil_sram_pkg::sram_cmd_t                 cmd,

  input  logic                                     rd_valid,
  output logic                                     rd_ready,
  input  axil_sram_pkg::sram_rd_t                  rd
);

  import axil_sram_pkg::*;

  logic last_wr;
  logic wr_pend;
  logic rd_pend;
  logic pick_wr;
  logic pick_rd;
  logic wr_xfer;
  logic rd_xfer;

  // a write needs both aw and w, plus room for its response
  assign wr_pend = awvalid && wvalid && !(bvalid && !bready);
  assign rd_pend = arvalid;

  // alternate when both kinds are waiting
  assign pick_wr = wr_pend && (!rd_pend || !last_wr);
  assign pick_rd = rd_pend && (!wr_pend || last_wr);

  assign cmd_valid = pick_wr || pick_rd;

  assign awready = pick_wr && cmd_ready;
  assign wready  = pick_wr && cmd_ready;
  assign arready = pick_rd && cmd_ready;

  assign wr_xfer = pick_wr && cmd_ready;
  assign rd_xfer = pick_rd && cmd_ready;

  always_comb begin
    cmd = '0;
    if (pick_wr) begin
      cmd.addr    = awaddr[AXIL_ADDR_WIDTH-1:WORD_LSB];
      cmd.wr_en   = 1'b1;
      cmd.wr_data = wdata;
      cmd.wr_strb = wstrb;
    end else begin
      // read, data and strobes stay zero
      cmd.addr  = araddr[AXIL_ADDR_WIDTH-1:WORD_LSB];
      cmd.wr_en = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_wr <= 1'b0;
    end else if (wr_xfer) begin
      last_wr <= 1'b1;
    end else if (rd_xfer) begin
      last_wr <= 1'b0;
    end
  end

  // write response, held until bready
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
    end else if (wr_xfer) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  assign bresp = RESP_OKAY;

  // read data comes back in order through the response path
  assign rvalid   = rd_valid;
  assign rdata    = rd.rd_data;
  assign rresp    = RESP_OKAY;
  assign rd_ready = rready;

endmodule

// File: design/sram_skid_buf.sv
module sram_skid_buf #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     skid_valid;
  payload_t skid_data;
  logic     in_xfer;
  logic     out_free;

  assign in_ready = !skid_valid;
  assign in_xfer  = in_valid && in_ready;
  // output register empty or draining this cycle
  assign out_free = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      out_valid  <= skid_valid || in_xfer;
      skid_valid <= 1'b0;
    end else if (in_xfer) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      out_data <= skid_valid ? skid_data : in_data;
    end else if (in_xfer) begin
      skid_data <= in_data;
    end
  end

endmodule

// File: design/sram_bank.sv
module sram_bank (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     cmd_valid,
  output logic                     cmd_ready,
  input  axil_sram_pkg::sram_cmd_t cmd,
  output logic                     rd_valid,
  input  logic                     rd_ready,
  output axil_sram_pkg::sram_rd_t  rd
);

  import axil_sram_pkg::*;

  localparam int DEPTH = 2 ** SRAM_ADDR_WIDTH;

  logic [AXIL_DATA_WIDTH-1:0] mem [DEPTH];
  logic                       cmd_xfer;
  sram_rd_t                   rd_q;

  // stall commands while a read response waits
  assign cmd_ready = !rd_valid || rd_ready;
  assign cmd_xfer  = cmd_valid && cmd_ready;

  always_ff @(posedge clk) begin
    if (cmd_xfer && cmd.wr_en) begin
      for (int i = 0; i < STRB_WIDTH; i++) begin
        if (cmd.wr_strb[i]) begin
          mem[cmd.addr][8*i +: 8] <= cmd.wr_data[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_xfer && !cmd.wr_en) begin
      rd_q.rd_data <= mem[cmd.addr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else if (cmd_ready) begin
      rd_valid <= cmd_valid && !cmd.wr_en;
    end
  end

  assign rd = rd_q;

endmodule

// File: design/axil_sram_top.sv
module axil_sram_top (
  input  logic                                     clk,
  input  logic                                     rst_n,

  input  logic [axil_sram_pkg::AXIL_ADDR_WIDTH-1:0] awaddr,
  input  logic                                     awvalid,
  output logic                                     awready,
  input  logic [axil_sram_pkg::AXIL_DATA_WIDTH-1:0] wdata,
  input  logic [axil_sram_pkg::STRB_WIDTH-1:0]      wstrb,
  input  logic                                     wvalid,
  output logic                                     wready,
  output logic [1:0]                               bresp,
  output logic                                     bvalid,
  input  logic                                     bready,

  input  logic [axil_sram_pkg::AXIL_ADDR_WIDTH-1:0] araddr,
  input  logic                                     arvalid,
  output logic                                     arready,
  output logic [axil_sram_pkg::AXIL_DATA_WIDTH-1:0] rdata,
  output logic [1:0]                               rresp,
  output logic                                     rvalid,
  input  logic                                     rready
);

  import axil_sram_pkg::*;

  logic      cmd_valid;
  logic      cmd_ready;
  sram_cmd_t cmd;
  logic      bank_cmd_valid;
  logic      bank_cmd_ready;
  sram_cmd_t bank_cmd;

  logic      bank_rd_valid;
  logic      bank_rd_ready;
  sram_rd_t  bank_rd;
  logic      rd_valid;
  logic      rd_ready;
  sram_rd_t  rd;

  axil_sram_bridge bridge (
    .clk      (clk),
    .rst_n    (rst_n),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .wready   (wready),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .bready   (bready),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata),
    .rresp    (rresp),
    .rvalid   (rvalid),
    .rready   (rready),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .cmd      (cmd),
    .rd_valid (rd_valid),
    .rd_ready (rd_ready),
    .rd       (rd)
  );

  sram_skid_buf #(.payload_t(sram_cmd_t)) cmd_skid (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (cmd_valid),
    .in_ready (cmd_ready),
    .in_data  (cmd),
    .out_valid(bank_cmd_valid),
    .out_ready(bank_cmd_ready),
    .out_data (bank_cmd)
  );

  sram_bank bank (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_valid(bank_cmd_valid),
    .cmd_ready(bank_cmd_ready),
    .cmd      (bank_cmd),
    .rd_valid (bank_rd_valid),
    .rd_ready (bank_rd_ready),
    .rd       (bank_rd)
  );

  sram_skid_buf #(.payload_t(sram_rd_t)) rd_skid (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (bank_rd_valid),
    .in_ready (bank_rd_ready),
    .in_data  (bank_rd),
    .out_valid(rd_valid),
    .out_ready(rd_ready),
    .out_data (rd)
  );

endmodule

// File: sim/tb_clk_gen.sv
module tb_clk_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// File: sim/axil_sram_checker.sv
module axil_sram_checker (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic [axil_sram_pkg::AXIL_ADDR_WIDTH-1:0] awaddr,
  input  logic                                     awvalid,
  input  logic                                     awready,
  input  logic [axil_sram_pkg::AXIL_DATA_WIDTH-1:0] wdata,
  input  logic [axil_sram_pkg::STRB_WIDTH-1:0]      wstrb,
  input  logic                                     wvalid,
  input  logic                                     wready,
  input  logic [1:0]                               bresp,
  input  logic                                     bvalid,
  input  logic                                     bready,
  input  logic [axil_sram_pkg::AXIL_ADDR_WIDTH-1:0] araddr,
  input  logic                                     arvalid,
  input  logic                                     arready,
  input  logic [axil_sram_pkg::AXIL_DATA_WIDTH-1:0] rdata,
  input  logic [1:0]                               rresp,
  input  logic                                     rvalid,
  input  logic                                     rready,
  output int                                       errors,
  output int                                       n_wr,
  output int                                       n_b,
  output int                                       n_ar,
  output int                                       n_r
);

  import axil_sram_pkg::*;

  // reference memory, keyed by word address, with per-byte written flags
  logic [AXIL_DATA_WIDTH-1:0] model_mem [int];
  logic [STRB_WIDTH-1:0]      model_wr  [int];
  logic [AXIL_DATA_WIDTH-1:0] exp_data_q [$];
  logic [STRB_WIDTH-1:0]      exp_mask_q [$];

  logic                       rst_was_low;
  logic                       stim_seen;
  logic                       prev_rvalid;
  logic                       prev_rready;
  logic [AXIL_DATA_WIDTH-1:0] prev_rdata;
  logic                       prev_bvalid;
  logic                       prev_bready;

  function automatic logic [AXIL_DATA_WIDTH-1:0] byte_mask(input logic [STRB_WIDTH-1:0] m);
    logic [AXIL_DATA_WIDTH-1:0] bits;
    bits = '0;
    for (int i = 0; i < STRB_WIDTH; i++) begin
      if (m[i]) bits[8*i +: 8] = 8'hff;
    end
    return bits;
  endfunction

  initial begin
    errors      = 0;
    n_wr        = 0;
    n_b         = 0;
    n_ar        = 0;
    n_r         = 0;
    rst_was_low = 1'b0;
    stim_seen   = 1'b0;
    prev_rvalid = 1'b0;
    prev_rready = 1'b0;
    prev_rdata  = '0;
    prev_bvalid = 1'b0;
    prev_bready = 1'b0;
  end

  always @(posedge clk) begin
    int                         wa;
    int                         ra;
    logic [AXIL_DATA_WIDTH-1:0] exp_d;
    logic [STRB_WIDTH-1:0]      exp_m;
    if (!rst_n) begin
      // registers have been cleared by the previous reset edge
      if (rst_was_low && (bvalid || rvalid || awready || wready || arready)) begin
        $display("Fail %0t: handshake output high during reset", $time);
        errors++;
      end
      rst_was_low = 1'b1;
    end else begin
      if (awvalid || wvalid || arvalid) begin
        stim_seen = 1'b1;
      end
      if (!stim_seen && (bvalid || rvalid || awready || wready || arready)) begin
        $display("Fail %0t: handshake output high before any stimulus", $time);
        errors++;
      end
      if ((awvalid && awready) != (wvalid && wready)) begin
        $display("Fail %0t: aw and w did not transfer together", $time);
        errors++;
      end
      if (awready && !(awvalid && wvalid)) begin
        $display("Fail %0t: write accepted without both aw and w valid", $time);
        errors++;
      end
      if (awvalid && awready && wvalid && wready) begin
        wa = int'(awaddr >> WORD_LSB);
        if (!model_mem.exists(wa)) begin
          model_mem[wa] = '0;
          model_wr[wa]  = '0;
        end
        for (int i = 0; i < STRB_WIDTH; i++) begin
          if (wstrb[i]) begin
            model_mem[wa][8*i +: 8] = wdata[8*i +: 8];
            model_wr[wa][i]         = 1'b1;
          end
        end
        n_wr++;
      end
      if (arvalid && arready) begin
        ra = int'(araddr >> WORD_LSB);
        if (model_mem.exists(ra)) begin
          exp_data_q.push_back(model_mem[ra]);
          exp_mask_q.push_back(model_wr[ra]);
        end else begin
          exp_data_q.push_back('0);
          exp_mask_q.push_back('0);
        end
        n_ar++;
      end
      if (prev_rvalid && !prev_rready && (!rvalid || rdata !== prev_rdata)) begin
        $display("Fail %0t: stalled read response changed or dropped", $time);
        errors++;
      end
      if (prev_bvalid && !prev_bready && !bvalid) begin
        $display("Fail %0t: stalled write response dropped", $time);
        errors++;
      end
      if (rvalid && rready) begin
        if (exp_data_q.size() == 0) begin
          $display("Fail %0t: read response with no read outstanding", $time);
          errors++;
        end else begin
          exp_d = exp_data_q.pop_front();
          exp_m = exp_mask_q.pop_front();
          if (((rdata ^ exp_d) & byte_mask(exp_m)) !== '0) begin
            $display("Fail %0t: rdata %h, expected %h (byte mask %b)",
                     $time, rdata, exp_d, exp_m);
            errors++;
          end
        end
        if (rresp != RESP_OKAY) begin
          $display("Fail %0t: rresp %b is not OKAY", $time, rresp);
          errors++;
        end
        n_r++;
      end
      if (bvalid && bready) begin
        if (bresp != RESP_OKAY) begin
          $display("Fail %0t: bresp %b is not OKAY", $time, bresp);
          errors++;
        end
        n_b++;
        if (n_b > n_wr) begin
          $display("Fail %0t: more write responses than accepted writes", $time);
          errors++;
        end
      end
    end
    prev_rvalid = rvalid && rst_n;
    prev_rready = rready;
    prev_rdata  = rdata;
    prev_bvalid = bvalid && rst_n;
    prev_bready = bready;
  end

endmodule

// File: sim/axil_sram_assert.sv
module axil_sram_assert (
  input logic clk,
  input logic rst_n,
  input logic awvalid,
  input logic awready,
  input logic wvalid,
  input logic wready,
  input logic arvalid,
  input logic arready,
  input logic bvalid,
  input logic bready,
  input logic rvalid,
  input logic rready
);

  no_rd_wr_same_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    !(arvalid && arready && awvalid && awready))
    else $error("read and write accepted in the same cycle");

  aw_w_ready_equal: assert property (@(posedge clk) disable iff (!rst_n)
    awready == wready)
    else $error("awready differs from wready");

  bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  rvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");

endmodule

bind axil_sram_bridge axil_sram_assert bridge_assert (.*);

// File: sim/axil_sram_tb.sv
module axil_sram_tb;

  import axil_sram_pkg::*;

  localparam int NUM_TRANS = 400;
  localparam int TIMEOUT   = 1000;

  logic                       clk;
  logic                       rst_n;
  logic [AXIL_ADDR_WIDTH-1:0] awaddr;
  logic                       awvalid;
  logic                       awready;
  logic [AXIL_DATA_WIDTH-1:0] wdata;
  logic [STRB_WIDTH-1:0]      wstrb;
  logic                       wvalid;
  logic                       wready;
  logic [1:0]                 bresp;
  logic                       bvalid;
  logic                       bready;
  logic [AXIL_ADDR_WIDTH-1:0] araddr;
  logic                       arvalid;
  logic                       arready;
  logic [AXIL_DATA_WIDTH-1:0] rdata;
  logic [1:0]                 rresp;
  logic                       rvalid;
  logic                       rready;

  int          chk_errors;
  int          n_wr;
  int          n_b;
  int          n_ar;
  int          n_r;
  int          tb_errors;
  logic [31:0] lfsr_q;
  logic        bready_nxt;
  logic        rready_nxt;

  tb_clk_gen #(.PERIOD(20), .RESET_CYCLES(10)) clk_gen (.clk(clk), .rst_n(rst_n));

  axil_sram_top uut (.*);

  axil_sram_checker chk (
    .*,
    .errors(chk_errors)
  );

  // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  // small window so reads hit written words
  function automatic logic [AXIL_ADDR_WIDTH-1:0] pick_addr();
    return AXIL_ADDR_WIDTH'(16'h0200 + rand_bits(4));
  endfunction

  task automatic write_one(
    input  logic [AXIL_ADDR_WIDTH-1:0] addr,
    input  logic [AXIL_DATA_WIDTH-1:0] data,
    input  logic [STRB_WIDTH-1:0]      strb,
    input  int                         delay,
    input  bit                         w_first,
    output bit                         ok
  );
    int t;
    @(posedge clk);
    awaddr <= addr;
    wdata  <= data;
    wstrb  <= strb;
    if (w_first) wvalid <= 1'b1;
    else awvalid <= 1'b1;
    repeat (delay) @(posedge clk);
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    t = 0;
    ok = 1'b0;
    while (!ok && t < TIMEOUT) begin
      @(posedge clk);
      ok = awvalid && awready && wvalid && wready;
      t++;
    end
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    if (!ok) $display("timeout waiting for write address and data to be accepted");
  endtask

  task automatic read_one(input logic [AXIL_ADDR_WIDTH-1:0] addr, output bit ok);
    int t;
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    t = 0;
    ok = 1'b0;
    while (!ok && t < TIMEOUT) begin
      @(posedge clk);
      ok = arvalid && arready;
      t++;
    end
    arvalid <= 1'b0;
    if (!ok) $display("timeout waiting for read address to be accepted");
  endtask

  task automatic drain_responses(output bit ok);
    int t;
    t = 0;
    ok = 1'b0;
    while (!ok && t < TIMEOUT) begin
      @(negedge clk);
      ok = (n_r == n_ar) && (n_b == n_wr);
      t++;
    end
    if (!ok) $display("timeout waiting for outstanding responses to drain");
  endtask

  // random response stalls, drawn at the falling edge
  always @(negedge clk) begin
    bready_nxt = rand_bits(2) != 32'd0;
    rready_nxt = rand_bits(2) != 32'd0;
  end

  always @(posedge clk) begin
    if (rst_n) begin
      bready <= bready_nxt;
      rready <= rready_nxt;
    end
  end

  initial begin
    bit                         ok;
    bit                         ok_w;
    bit                         ok_r;
    int                         t;
    logic [1:0]                 sel;
    logic [AXIL_ADDR_WIDTH-1:0] w_addr;
    logic [AXIL_ADDR_WIDTH-1:0] r_addr;
    logic [AXIL_DATA_WIDTH-1:0] w_data;
    logic [STRB_WIDTH-1:0]      w_strb;
    int                         w_delay;
    bit                         w_first;
    lfsr_q    = 32'hac7b_e130;
    tb_errors = 0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    ok        = 1'b1;
    t         = 0;
    while (rst_n !== 1'b1 && t < TIMEOUT) begin
      @(posedge clk);
      t++;
    end
    if (rst_n !== 1'b1) begin
      $display("timeout waiting for reset release");
      ok = 1'b0;
    end
    repeat (2) @(posedge clk);
    for (int i = 0; i < NUM_TRANS && ok; i++) begin
      sel     = 2'(rand_bits(2));
      w_addr  = pick_addr();
      w_data  = AXIL_DATA_WIDTH'(rand_bits(16));
      w_strb  = STRB_WIDTH'(rand_bits(STRB_WIDTH));
      w_delay = int'(rand_bits(2));
      w_first = 1'(rand_bits(1));
      r_addr  = pick_addr();
      if (sel == 2'd0) begin
        // write and read compete for the arbiter
        fork
          write_one(w_addr, w_data, w_strb, w_delay, w_first, ok_w);
          read_one(r_addr, ok_r);
        join
        ok = ok_w && ok_r;
      end else if (sel[0]) begin
        write_one(w_addr, w_data, w_strb, w_delay, w_first, ok);
      end else begin
        read_one(r_addr, ok);
      end
    end
    if (ok) begin
      drain_responses(ok);
      // quiet period so late extra responses are counted
      repeat (4) @(negedge clk);
    end
    if (!ok) tb_errors++;
    else if (n_r != n_ar || n_b != n_wr) tb_errors++;
    $display("errors: %0d (checker %0d, testbench %0d), writes %0d, reads %0d",
             chk_errors + tb_errors, chk_errors, tb_errors, n_wr, n_ar);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: verilog.f
design/axil_sram_pkg.sv
design/axil_sram_bridge.sv
design/sram_skid_buf.sv
design/sram_bank.sv
design/axil_sram_top.sv
sim/tb_clk_gen.sv
sim/axil_sram_checker.sv
sim/axil_sram_assert.sv
sim/axil_sram_tb.sv

// File: Bender.yml
package:
  name: axil_sram

sources:
  - files:
      - design/axil_sram_pkg.sv
      - design/axil_sram_bridge.sv
      - design/sram_skid_buf.sv
      - design/sram_bank.sv
      - design/axil_sram_top.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/axil_sram_checker.sv
      - sim/axil_sram_assert.sv
      - sim/axil_sram_tb.sv
